// ==== logic/btac_config_pkg.sv ====
`default_nettype none

package btac_config_pkg;

  // Address width of the fetch unit
  localparam int unsigned xlen = 32;

  // Tag PC, target and fall-through
  localparam int unsigned entry_bits = 3 * xlen;

  // Buffer entries unless the top level says otherwise
  localparam int unsigned default_depth = 64;

  // Address registers come out of reset at zero
  localparam logic [xlen-1:0] addr_reset = '0;

endpackage

`default_nettype wire

// ==== logic/btac_types_pkg.sv ====
`default_nettype none

package btac_types_pkg;

  import btac_config_pkg::*;

  // One buffer entry, tag in the top bits
  typedef struct packed {
    logic [xlen-1:0] tag;
    logic [xlen-1:0] target;
    logic [xlen-1:0] fallthrough;
  } btb_entry_t;

  // What one execute slot reports
  typedef struct packed {
    logic            jal;
    logic            jalr;
    logic            branch;
    logic            jump;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] npc;
    logic [xlen-1:0] addr;
  } slot_update_t;

  // Slot report after the priority choice
  typedef struct packed {
    logic            valid;
    logic            jal;
    logic            jalr;
    logic            branch;
    logic            jump;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] npc;
    logic [xlen-1:0] addr;
  } resolved_update_t;

endpackage

`default_nettype wire

// ==== logic/btb_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface btb_port_if
  import btac_config_pkg::*;
#(
  parameter int unsigned btb_depth = default_depth
);

  localparam int unsigned index_bits = $clog2(btb_depth);

  logic                  wen;
  logic [index_bits-1:0] waddr;
  logic [index_bits-1:0] raddr;
  logic [entry_bits-1:0] wdata;
  logic [entry_bits-1:0] rdata;

  modport ctrl (output wen, output waddr, output raddr, output wdata, input rdata);

  modport store (input wen, input waddr, input raddr, input wdata, output rdata);

endinterface

`default_nettype wire

// ==== logic/btb_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module btb_store
  import btac_config_pkg::*;
  import btac_types_pkg::*;
#(
  parameter int unsigned btb_depth = default_depth
) (
  input logic       clock,
  btb_port_if.store mem
);

  // Empty entries read as all zero, which the hit test relies on
  btb_entry_t entries [btb_depth] = '{default: '0};

  // Lookup port, same cycle
  assign mem.rdata = entries[mem.raddr];

  always_ff @(posedge clock) begin
    if (mem.wen) begin
      entries[mem.waddr] <= mem.wdata;
    end
  end

endmodule

`default_nettype wire

// ==== logic/update_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module update_select
  import btac_types_pkg::*;
(
  input  slot_update_t     slot0,
  input  slot_update_t     slot1,
  output resolved_update_t chosen
);

  logic slot0_active;
  logic slot1_active;

  // Adds the valid flag to a slot report
  function automatic resolved_update_t promote(input slot_update_t s);
    resolved_update_t r;
    r.valid  = 1'b1;
    r.jal    = s.jal;
    r.jalr   = s.jalr;
    r.branch = s.branch;
    r.jump   = s.jump;
    r.pc     = s.pc;
    r.npc    = s.npc;
    r.addr   = s.addr;
    return r;
  endfunction

  // A slot carries a transfer if any kind bit is set
  assign slot0_active = slot0.jal || slot0.jalr || slot0.branch;
  assign slot1_active = slot1.jal || slot1.jalr || slot1.branch;

  // Older instruction sits in slot 0
  always_comb begin
    if (slot0_active) begin
      chosen = promote(slot0);
    end else if (slot1_active) begin
      chosen = promote(slot1);
    end else begin
      chosen = '0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/target_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module target_check
  import btac_config_pkg::*;
  import btac_types_pkg::*;
(
  input  logic             clock,
  input  logic             reset,
  input  logic             fetch_taken,
  input  logic             flush,
  input  logic             consume,
  input  logic [xlen-1:0]  fetch_target,
  input  logic [xlen-1:0]  fetch_next,
  input  resolved_update_t chosen,
  output logic             miss,
  output logic [xlen-1:0]  miss_addr
);

  logic            rec_valid;
  logic [xlen-1:0] rec_target;
  logic [xlen-1:0] rec_next;
  logic            load_now;
  logic            eff_valid;
  logic [xlen-1:0] eff_target;
  logic [xlen-1:0] eff_next;

  // A record loaded this cycle already counts for the compare
  assign load_now   = fetch_taken && !flush;
  assign eff_valid  = load_now || rec_valid;
  assign eff_target = load_now ? fetch_target : rec_target;
  assign eff_next   = load_now ? fetch_next : rec_next;

  always_ff @(posedge clock) begin
    if (!reset) begin
      rec_valid  <= 1'b0;
      rec_target <= addr_reset;
      rec_next   <= addr_reset;
    end else if (flush || consume) begin
      rec_valid <= 1'b0;
    end else if (fetch_taken) begin
      rec_valid  <= 1'b1;
      rec_target <= fetch_target;
      rec_next   <= fetch_next;
    end
  end

  // consume is only high for a resolved branch outside of clear
  always_comb begin
    miss      = 1'b0;
    miss_addr = addr_reset;
    if (consume) begin
      if (!eff_valid) begin
        // Predicted not taken, went taken
        miss      = chosen.jump;
        miss_addr = chosen.jump ? chosen.addr : addr_reset;
      end else if (!chosen.jump) begin
        miss      = 1'b1;
        miss_addr = eff_next;
      end else begin
        miss      = chosen.addr != eff_target;
        miss_addr = chosen.addr;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/btac_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module btac_ctrl
  import btac_config_pkg::*;
  import btac_types_pkg::*;
#(
  parameter int unsigned btb_depth = default_depth
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             clear,
  input  logic [xlen-1:0]  fetch_pc,
  input  resolved_update_t chosen,
  btb_port_if.ctrl         mem,
  output logic             flush,
  output logic             consume,
  output logic             pred_hit,
  output logic [xlen-1:0]  pred_target,
  output logic [xlen-1:0]  pred_pc,
  output logic             ret_valid,
  output logic [xlen-1:0]  ret_addr
);

  localparam int unsigned index_bits = $clog2(btb_depth);

  logic [index_bits-1:0] last_index;
  logic [xlen-1:0]       last_pc;
  logic [index_bits-1:0] fetch_index;
  logic [xlen-1:0]       lookup_pc;
  btb_entry_t            rentry;
  logic                  hit;
  logic                  is_branch;
  logic                  is_return;

  // Halfword aligned PCs, bit 0 carries no information
  assign fetch_index = fetch_pc[index_bits:1];

  // Last read stays on the port while flushed
  assign mem.raddr = clear ? last_index : fetch_index;
  assign lookup_pc = clear ? last_pc : fetch_pc;

  always_ff @(posedge clock) begin
    if (!reset) begin
      last_index <= '0;
      last_pc    <= addr_reset;
    end else if (!clear) begin
      last_index <= fetch_index;
      last_pc    <= fetch_pc;
    end
  end

  assign rentry = btb_entry_t'(mem.rdata);
  assign hit    = (|mem.rdata) && (rentry.tag == lookup_pc);

  assign is_branch = chosen.valid && chosen.branch;
  assign is_return = chosen.jal || chosen.jalr;

  // Only taken conditional branches allocate
  assign mem.wen   = !clear && is_branch && chosen.jump;
  assign mem.waddr = chosen.pc[index_bits:1];
  assign mem.wdata = {chosen.pc, chosen.addr, chosen.npc};

  assign flush   = clear;
  assign consume = !clear && is_branch;

  always_comb begin
    if (clear) begin
      pred_hit    = 1'b0;
      pred_target = addr_reset;
      pred_pc     = addr_reset;
      ret_valid   = 1'b0;
      ret_addr    = addr_reset;
    end else begin
      pred_hit    = hit;
      pred_target = rentry.target;
      pred_pc     = rentry.fallthrough;
      ret_valid   = is_return;
      ret_addr    = chosen.addr;
    end
  end

endmodule

`default_nettype wire

// ==== logic/btac.sv ====
`timescale 1ns/1ps
`default_nettype none

module btac
  import btac_config_pkg::*;
  import btac_types_pkg::*;
#(
  parameter int unsigned btb_depth = default_depth
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            clear,
  input  logic [xlen-1:0] fetch_pc,
  input  logic            fetch_taken,
  input  logic [xlen-1:0] fetch_target,
  input  logic [xlen-1:0] fetch_next,
  input  logic            slot0_jal,
  input  logic            slot0_jalr,
  input  logic            slot0_branch,
  input  logic            slot0_jump,
  input  logic [xlen-1:0] slot0_pc,
  input  logic [xlen-1:0] slot0_npc,
  input  logic [xlen-1:0] slot0_addr,
  input  logic            slot1_jal,
  input  logic            slot1_jalr,
  input  logic            slot1_branch,
  input  logic            slot1_jump,
  input  logic [xlen-1:0] slot1_pc,
  input  logic [xlen-1:0] slot1_npc,
  input  logic [xlen-1:0] slot1_addr,
  output logic            pred_hit,
  output logic [xlen-1:0] pred_target,
  output logic [xlen-1:0] pred_pc,
  output logic            miss,
  output logic [xlen-1:0] miss_addr,
  output logic            ret_valid,
  output logic [xlen-1:0] ret_addr
);

  slot_update_t     slot0;
  slot_update_t     slot1;
  resolved_update_t chosen;
  logic             flush;
  logic             consume;

  assign slot0 = '{jal: slot0_jal, jalr: slot0_jalr, branch: slot0_branch, jump: slot0_jump,
                   pc: slot0_pc, npc: slot0_npc, addr: slot0_addr};
  assign slot1 = '{jal: slot1_jal, jalr: slot1_jalr, branch: slot1_branch, jump: slot1_jump,
                   pc: slot1_pc, npc: slot1_npc, addr: slot1_addr};

  btb_port_if #(.btb_depth(btb_depth)) btb_port ();

  btb_store #(.btb_depth(btb_depth)) u_store (
    .clock (clock),
    .mem   (btb_port.store)
  );

  update_select u_select (
    .slot0  (slot0),
    .slot1  (slot1),
    .chosen (chosen)
  );

  target_check u_check (
    .clock        (clock),
    .reset        (reset),
    .fetch_taken  (fetch_taken),
    .flush        (flush),
    .consume      (consume),
    .fetch_target (fetch_target),
    .fetch_next   (fetch_next),
    .chosen       (chosen),
    .miss         (miss),
    .miss_addr    (miss_addr)
  );

  btac_ctrl #(.btb_depth(btb_depth)) u_ctrl (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .fetch_pc    (fetch_pc),
    .chosen      (chosen),
    .mem         (btb_port.ctrl),
    .flush       (flush),
    .consume     (consume),
    .pred_hit    (pred_hit),
    .pred_target (pred_target),
    .pred_pc     (pred_pc),
    .ret_valid   (ret_valid),
    .ret_addr    (ret_addr)
  );

endmodule

`default_nettype wire

// ==== tb/clock_source.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_source #(
  parameter int half_period  = 20,
  parameter int reset_cycles = 2
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(half_period) clock = ~clock;
  end

  // Reset is active low and released away from the rising edge
  initial begin
    reset = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/btac_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module btac_tb;

  localparam int depth    = 64;
  localparam int idx_bits = 6;

  // Kind bits are {jal, jalr, branch, jump}
  localparam logic [3:0] k_none      = 4'b0000;
  localparam logic [3:0] k_taken     = 4'b0011;
  localparam logic [3:0] k_not_taken = 4'b0010;
  localparam logic [3:0] k_jal       = 4'b1001;
  localparam logic [3:0] k_jalr      = 4'b0101;

  logic        clock;
  logic        reset;
  logic        clear;
  logic        fetch_taken;
  logic [31:0] fetch_pc, fetch_target, fetch_next;
  logic        slot0_jal, slot0_jalr, slot0_branch, slot0_jump;
  logic [31:0] slot0_pc, slot0_npc, slot0_addr;
  logic        slot1_jal, slot1_jalr, slot1_branch, slot1_jump;
  logic [31:0] slot1_pc, slot1_npc, slot1_addr;
  logic        pred_hit, miss, ret_valid;
  logic [31:0] pred_target, pred_pc, miss_addr, ret_addr;

  // Reference model state
  logic [31:0] shadow_tag [depth] = '{default: '0};
  logic [31:0] shadow_target [depth] = '{default: '0};
  logic [31:0] shadow_next [depth] = '{default: '0};
  logic        rec_valid;
  logic [31:0] rec_target, rec_next;
  logic        c_valid, c_jal, c_jalr, c_branch, c_jump;
  logic [31:0] c_pc, c_npc, c_addr;
  logic        consume_m, load_m, eff_valid;
  logic [31:0] eff_target, eff_next;
  logic        exp_hit, exp_miss, exp_ret_valid;
  logic [31:0] exp_target, exp_pc, exp_miss_addr, exp_ret_addr;

  logic [15:0] lfsr = 16'd64;
  int          value_errors = 0;
  int          timeout_errors = 0;

  clock_source clocks (.clock(clock), .reset(reset));

  btac #(.btb_depth(depth)) dut0 (.*);

  always_comb begin
    {c_valid, c_jal, c_jalr, c_branch, c_jump, c_pc, c_npc, c_addr} = '0;
    if (slot0_jal || slot0_jalr || slot0_branch) begin
      {c_jal, c_jalr, c_branch, c_jump} = {slot0_jal, slot0_jalr, slot0_branch, slot0_jump};
      {c_valid, c_pc, c_npc, c_addr} = {1'b1, slot0_pc, slot0_npc, slot0_addr};
    end else if (slot1_jal || slot1_jalr || slot1_branch) begin
      {c_jal, c_jalr, c_branch, c_jump} = {slot1_jal, slot1_jalr, slot1_branch, slot1_jump};
      {c_valid, c_pc, c_npc, c_addr} = {1'b1, slot1_pc, slot1_npc, slot1_addr};
    end
    exp_hit    = !clear && (shadow_tag[fetch_pc[idx_bits:1]] == fetch_pc)
                 && ((shadow_tag[fetch_pc[idx_bits:1]] | shadow_target[fetch_pc[idx_bits:1]]
                 | shadow_next[fetch_pc[idx_bits:1]]) != '0);
    exp_target = clear ? '0 : shadow_target[fetch_pc[idx_bits:1]];
    exp_pc     = clear ? '0 : shadow_next[fetch_pc[idx_bits:1]];
    // Record taken this cycle already counts
    consume_m  = !clear && c_valid && c_branch;
    load_m     = fetch_taken && !clear;
    eff_valid  = load_m || rec_valid;
    eff_target = load_m ? fetch_target : rec_target;
    eff_next   = load_m ? fetch_next : rec_next;
    exp_miss      = 1'b0;
    exp_miss_addr = '0;
    if (consume_m && !eff_valid) begin
      exp_miss      = c_jump;
      exp_miss_addr = c_jump ? c_addr : '0;
    end else if (consume_m && !c_jump) begin
      exp_miss      = 1'b1;
      exp_miss_addr = eff_next;
    end else if (consume_m) begin
      exp_miss      = c_addr != eff_target;
      exp_miss_addr = c_addr;
    end
    exp_ret_valid = !clear && (c_jal || c_jalr);
    exp_ret_addr  = clear ? '0 : c_addr;
  end

  always @(posedge clock) begin
    if (!reset || clear || consume_m) begin
      rec_valid <= 1'b0;
    end else if (fetch_taken) begin
      rec_valid  <= 1'b1;
      rec_target <= fetch_target;
      rec_next   <= fetch_next;
    end
    if (!clear && c_valid && c_branch && c_jump) begin
      shadow_tag[c_pc[idx_bits:1]]    <= c_pc;
      shadow_target[c_pc[idx_bits:1]] <= c_addr;
      shadow_next[c_pc[idx_bits:1]]   <= c_npc;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    value_errors++;
    $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, want);
  endtask

  pred_hit_ok: assert property (@(posedge clock) disable iff (!reset) pred_hit == exp_hit)
    else report_mismatch("pred_hit", 32'($sampled(pred_hit)), 32'($sampled(exp_hit)));
  pred_target_ok: assert property (@(posedge clock) disable iff (!reset) pred_target == exp_target)
    else report_mismatch("pred_target", $sampled(pred_target), $sampled(exp_target));
  pred_pc_ok: assert property (@(posedge clock) disable iff (!reset) pred_pc == exp_pc)
    else report_mismatch("pred_pc", $sampled(pred_pc), $sampled(exp_pc));
  miss_ok: assert property (@(posedge clock) disable iff (!reset) miss == exp_miss)
    else report_mismatch("miss", 32'($sampled(miss)), 32'($sampled(exp_miss)));
  miss_addr_ok: assert property (@(posedge clock) disable iff (!reset) miss_addr == exp_miss_addr)
    else report_mismatch("miss_addr", $sampled(miss_addr), $sampled(exp_miss_addr));
  ret_valid_ok: assert property (@(posedge clock) disable iff (!reset) ret_valid == exp_ret_valid)
    else report_mismatch("ret_valid", 32'($sampled(ret_valid)), 32'($sampled(exp_ret_valid)));
  ret_addr_ok: assert property (@(posedge clock) disable iff (!reset) ret_addr == exp_ret_addr)
    else report_mismatch("ret_addr", $sampled(ret_addr), $sampled(exp_ret_addr));

  // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_bits(input int n, output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < n; i++) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [3:0] kind_of(input logic [2:0] code);
    case (code)
      3'd0, 3'd1: return k_taken;
      3'd2, 3'd3: return k_not_taken;
      3'd4: return k_jal;
      3'd5: return k_jalr;
      default: return k_none;
    endcase
  endfunction

  task automatic set_slot(input int which, input logic [3:0] kind,
                          input logic [31:0] pc, input logic [31:0] npc,
                          input logic [31:0] addr);
    if (which == 0) begin
      {slot0_jal, slot0_jalr, slot0_branch, slot0_jump} = kind;
      {slot0_pc, slot0_npc, slot0_addr} = {pc, npc, addr};
    end else begin
      {slot1_jal, slot1_jalr, slot1_branch, slot1_jump} = kind;
      {slot1_pc, slot1_npc, slot1_addr} = {pc, npc, addr};
    end
  endtask

  task automatic set_record(input logic [31:0] target, input logic [31:0] next);
    fetch_taken  = 1'b1;
    fetch_target = target;
    fetch_next   = next;
  endtask

  task automatic idle_inputs();
    clear = 1'b0;
    fetch_pc = '0;
    set_record('0, '0);
    fetch_taken = 1'b0;
    set_slot(0, k_none, '0, '0, '0);
    set_slot(1, k_none, '0, '0, '0);
  endtask

  // New inputs go out on the falling edge
  task automatic begin_cycle();
    @(negedge clock);
    idle_inputs();
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (!reset && n < 10) begin
      @(negedge clock);
      n++;
    end
    if (!reset) begin
      timeout_errors++;
      $display("Reset was still asserted after %0d cycles", n);
    end
  endtask

  task automatic random_update(input int which);
    logic [31:0] r;
    logic [31:0] pc;
    logic [3:0]  kind;
    random_bits(3, r);
    kind = kind_of(r[2:0]);
    random_bits(7, r);
    pc = 32'h4000 + (r << 1);
    random_bits(3, r);
    set_slot(which, kind, pc, pc + 4, 32'h8000 + (r << 2));
  endtask

  initial begin
    logic [31:0] r;
    int n;
    idle_inputs();
    wait_reset_release();
    // Empty buffer
    begin_cycle();
    fetch_pc = 32'h1008;
    begin_cycle();
    fetch_pc = 32'h2222;
    // Allocate, hit, then same index with another tag
    begin_cycle();
    set_slot(0, k_taken, 32'h1008, 32'h100c, 32'h2000);
    begin_cycle();
    fetch_pc = 32'h1008;
    begin_cycle();
    fetch_pc = 32'h1088;
    // Slot priority
    begin_cycle();
    set_slot(0, k_taken, 32'h1104, 32'h1108, 32'h3000);
    set_slot(1, k_taken, 32'h1110, 32'h1114, 32'h3100);
    begin_cycle();
    fetch_pc = 32'h1110;
    begin_cycle();
    fetch_pc = 32'h1104;
    set_slot(0, k_jal, 32'h1130, 32'h1134, 32'h3300);
    set_slot(1, k_taken, 32'h1138, 32'h113c, 32'h3380);
    begin_cycle();
    fetch_pc = 32'h1138;
    set_slot(1, k_taken, 32'h1120, 32'h1124, 32'h3200);
    begin_cycle();
    fetch_pc = 32'h1120;
    // Miss rules where each consumes the record
    begin_cycle();
    set_slot(0, k_taken, 32'h1200, 32'h1204, 32'h4000);
    begin_cycle();
    set_record(32'h5000, 32'h1304);
    begin_cycle();
    set_slot(0, k_not_taken, 32'h1300, 32'h1304, 32'h5000);
    begin_cycle();
    set_record(32'h5100, 32'h1404);
    begin_cycle();
    set_slot(0, k_taken, 32'h1400, 32'h1404, 32'h5100);
    begin_cycle();
    set_record(32'h5200, 32'h1504);
    begin_cycle();
    set_slot(0, k_taken, 32'h1500, 32'h1504, 32'h5280);
    begin_cycle();
    set_record(32'h5300, 32'h1584);
    set_slot(1, k_taken, 32'h1580, 32'h1584, 32'h5300);
    begin_cycle();
    set_slot(0, k_not_taken, 32'h1600, 32'h1604, 32'h5400);
    // Jumps report a return address and never allocate
    begin_cycle();
    set_slot(0, k_jal, 32'h1700, 32'h1704, 32'h6000);
    begin_cycle();
    set_slot(1, k_jalr, 32'h1710, 32'h1714, 32'h6100);
    begin_cycle();
    fetch_pc = 32'h1700;
    begin_cycle();
    fetch_pc = 32'h1710;
    // Flush drops the record and blocks the write
    begin_cycle();
    set_record(32'h7000, 32'h1804);
    begin_cycle();
    clear = 1'b1;
    fetch_pc = 32'h1008;
    set_record(32'h7080, 32'h1884);
    set_slot(0, k_taken, 32'h1800, 32'h1804, 32'h7100);
    set_slot(1, k_jal, 32'h1810, 32'h1814, 32'h7200);
    begin_cycle();
    fetch_pc = 32'h1800;
    begin_cycle();
    set_slot(0, k_not_taken, 32'h1900, 32'h1904, 32'h7300);
    // Random traffic over a small address window
    for (n = 0; n < 64; n++) begin
      begin_cycle();
      random_bits(4, r);
      clear = (r[3:0] == 4'd0);
      random_bits(7, r);
      fetch_pc = 32'h4000 + (r << 1);
      random_bits(1, r);
      fetch_taken = r[0];
      random_bits(3, r);
      fetch_target = 32'h8000 + (r << 2);
      fetch_next = fetch_pc + 4;
      random_update(0);
      random_update(1);
    end
    begin_cycle();
    begin_cycle();
    $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
    if (value_errors + timeout_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/btac_config_pkg.sv
logic/btac_types_pkg.sv
logic/btb_port_if.sv
logic/btb_store.sv
logic/update_select.sv
logic/target_check.sv
logic/btac_ctrl.sv
logic/btac.sv
tb/clock_source.sv
tb/btac_tb.sv
